//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_fetch
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal
PASS_MSG  ?= Done: no errors

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run $(TOP), look for the pass line"
	@echo "  clean  remove $(BUILD_DIR)"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out="$$($(BUILD_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

//--- hw/fetch_pkg.sv
`default_nettype none

package fetch_pkg;

    // widths with a meaning of their own
    typedef logic [31:0]  addr_t;       // byte address
    typedef logic [31:0]  word_t;       // one instruction
    typedef logic [63:0]  beat_t;       // one burst beat from memory
    typedef logic [255:0] line_t;       // 32-byte cache line
    typedef logic [26:0]  line_tag_t;   // address above the line offset

    localparam addr_t reset_pc = 32'h1eceb000;

    localparam int beats_per_line = 4;
    localparam int queue_depth = 16;

    // what the cache answers with and the queue holds
    typedef struct packed {
        addr_t pc;
        word_t inst;
    } fetch_pkt_t;

    // miss sequencing
    typedef enum logic [1:0] {
        idle,
        request,    // waiting for memory ready
        wait_line   // burst in flight
    } cache_state_t;

endpackage : fetch_pkg

`default_nettype wire

//--- hw/fetch_top.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_top
import fetch_pkg::*;
(
    input  logic       clk,
    input  logic       rst,

    // burst memory
    output addr_t      bmem_addr_o,
    output logic       bmem_read_o,
    input  logic       bmem_ready_i,
    input  addr_t      bmem_raddr_i,
    input  beat_t      bmem_rdata_i,
    input  logic       bmem_rvalid_i,

    // rename/dispatch side
    output fetch_pkt_t fetch_pkt_o,
    output logic       fetch_empty_o,
    input  logic       dequeue_i
);

    addr_t      pc_q;
    logic       start_q;    // free to issue, nothing outstanding
    logic       issue;

    logic       fetch_resp;
    fetch_pkt_t resp_pkt;
    logic       queue_full;

    addr_t      line_addr;
    line_t      line_data;
    logic       line_valid;
    logic       line_fill;

    assign issue = (start_q || fetch_resp) && !queue_full;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc_q    <= reset_pc;
            start_q <= 1'b1;
        end else begin
            if (issue) begin
                pc_q    <= pc_q + 32'd4;
                start_q <= 1'b0;
            end else if (fetch_resp) begin
                start_q <= 1'b1;    // answered while full, resume later
            end
        end
    end

    // only a burst for the outstanding refill fills the line
    assign line_fill = line_valid && (line_addr[31:5] == bmem_addr_o[31:5]);

    line_adapter adapter_i (
        .clk          (clk),
        .rst          (rst),
        .beat_addr_i  (bmem_raddr_i),
        .beat_data_i  (bmem_rdata_i),
        .beat_valid_i (bmem_rvalid_i),
        .line_addr_o  (line_addr),
        .line_data_o  (line_data),
        .line_valid_o (line_valid)
    );

    line_cache cache_i (
        .clk           (clk),
        .rst           (rst),
        .fetch_req_i   (issue),
        .fetch_pc_i    (pc_q),
        .fetch_resp_o  (fetch_resp),
        .resp_pkt_o    (resp_pkt),
        .mem_ready_i   (bmem_ready_i),
        .refill_read_o (bmem_read_o),
        .refill_addr_o (bmem_addr_o),
        .line_valid_i  (line_fill),
        .line_data_i   (line_data)
    );

    inst_queue queue_i (
        .clk        (clk),
        .rst        (rst),
        .enq_i      (fetch_resp),
        .enq_pkt_i  (resp_pkt),
        .deq_i      (dequeue_i),
        .head_pkt_o (fetch_pkt_o),
        .full_o     (queue_full),
        .empty_o    (fetch_empty_o)
    );

endmodule : fetch_top

`default_nettype wire

//--- hw/inst_queue.sv
`timescale 1ns/1ps
`default_nettype none

module inst_queue
import fetch_pkg::*;
(
    input  logic       clk,
    input  logic       rst,

    input  logic       enq_i,
    input  fetch_pkt_t enq_pkt_i,
    input  logic       deq_i,

    output fetch_pkt_t head_pkt_o,
    output logic       full_o,
    output logic       empty_o
);

    localparam int ptr_w = $clog2(queue_depth);
    localparam int cnt_w = $clog2(queue_depth + 1);

    fetch_pkt_t mem [queue_depth];

    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [cnt_w-1:0] count;
    logic             do_enq;
    logic             do_deq;

    assign do_enq = enq_i && (count != cnt_w'(queue_depth));
    assign do_deq = deq_i && !empty_o;     // pop on empty is ignored

    assign empty_o = (count == '0);
    // keeps one slot free for the response already in flight
    assign full_o  = (count >= cnt_w'(queue_depth - 1));

    assign head_pkt_o = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_enq) wr_ptr <= wr_ptr + 1'b1;
            if (do_deq) rd_ptr <= rd_ptr + 1'b1;
            if (do_enq && !do_deq) begin
                count <= count + 1'b1;
            end else if (do_deq && !do_enq) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (do_enq) mem[wr_ptr] <= enq_pkt_i;
    end

endmodule : inst_queue

`default_nettype wire

//--- hw/line_adapter.sv
`timescale 1ns/1ps
`default_nettype none

module line_adapter
import fetch_pkg::*;
(
    input  logic  clk,
    input  logic  rst,

    input  addr_t beat_addr_i,
    input  beat_t beat_data_i,
    input  logic  beat_valid_i,

    output addr_t line_addr_o,
    output line_t line_data_o,
    output logic  line_valid_o
);

    localparam int cnt_w = $clog2(beats_per_line);

    logic [cnt_w-1:0] beat_cnt;
    logic             last_beat;

    assign last_beat = (beat_cnt == cnt_w'(beats_per_line - 1));

    // beat counter and completion pulse
    always_ff @(posedge clk) begin
        if (rst) begin
            beat_cnt     <= '0;
            line_valid_o <= 1'b0;
        end else begin
            line_valid_o <= 1'b0;
            if (beat_valid_i) begin
                if (last_beat) begin
                    beat_cnt     <= '0;     // ready for next burst
                    line_valid_o <= 1'b1;
                end else begin
                    beat_cnt <= beat_cnt + 1'b1;
                end
            end
        end
    end

    // lowest 8 bytes arrive first
    always_ff @(posedge clk) begin
        if (beat_valid_i) begin
            line_data_o[beat_cnt*$bits(beat_t) +: $bits(beat_t)] <= beat_data_i;
            line_addr_o <= beat_addr_i;     // same for every beat of a burst
        end
    end

endmodule : line_adapter

`default_nettype wire

//--- hw/line_cache.sv
`timescale 1ns/1ps
`default_nettype none

module line_cache
import fetch_pkg::*;
(
    input  logic       clk,
    input  logic       rst,

    // pc side
    input  logic       fetch_req_i,
    input  addr_t      fetch_pc_i,
    output logic       fetch_resp_o,
    output fetch_pkt_t resp_pkt_o,

    // refill side
    input  logic       mem_ready_i,
    output logic       refill_read_o,
    output addr_t      refill_addr_o,
    input  logic       line_valid_i,
    input  line_t      line_data_i
);

    cache_state_t state;

    line_t     line_q;
    line_tag_t tag_q;
    logic      valid_q;
    addr_t     pend_pc;     // pc that missed
    logic      hit;

    // word at pc within a line
    function automatic word_t select_word(input line_t line, input addr_t pc);
        logic [2:0] idx;
        idx = pc[4:2];
        return line[idx*$bits(word_t) +: $bits(word_t)];
    endfunction

    assign hit = valid_q && (tag_q == line_tag_t'(fetch_pc_i[31:5]));

    // one-cycle strobe, only while memory is ready
    assign refill_read_o = (state == request) && mem_ready_i;
    assign refill_addr_o = {pend_pc[31:5], 5'b0};

    always_ff @(posedge clk) begin
        if (rst) begin
            state        <= idle;
            valid_q      <= 1'b0;
            fetch_resp_o <= 1'b0;
        end else begin
            fetch_resp_o <= 1'b0;
            unique case (state)
                idle: begin
                    if (fetch_req_i) begin
                        if (hit) begin
                            fetch_resp_o <= 1'b1;
                        end else begin
                            state <= request;
                        end
                    end
                end
                request: begin
                    if (mem_ready_i) state <= wait_line;
                end
                wait_line: begin
                    if (line_valid_i) begin
                        valid_q      <= 1'b1;
                        fetch_resp_o <= 1'b1;   // answer the missed pc next cycle
                        state        <= idle;
                    end
                end
                default: state <= idle;
            endcase
        end
    end

    // line storage and response data
    always_ff @(posedge clk) begin
        if (state == idle && fetch_req_i) begin
            pend_pc         <= fetch_pc_i;
            resp_pkt_o.pc   <= fetch_pc_i;
            resp_pkt_o.inst <= select_word(line_q, fetch_pc_i);
        end
        if (state == wait_line && line_valid_i) begin
            line_q          <= line_data_i;
            tag_q           <= line_tag_t'(pend_pc[31:5]);
            resp_pkt_o.pc   <= pend_pc;
            resp_pkt_o.inst <= select_word(line_data_i, pend_pc);   // bypass new line
        end
    end

endmodule : line_cache

`default_nettype wire

//--- sources.f
hw/fetch_pkg.sv
hw/line_adapter.sv
hw/line_cache.sv
hw/inst_queue.sv
hw/fetch_top.sv
verification/bmem_model.sv
verification/tb_fetch.sv

//--- verification/bmem_model.sv
`timescale 1ns/1ps
`default_nettype none

module bmem_model
import fetch_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  addr_t      addr_i,
    input  logic       read_i,
    output logic       ready_o,
    output addr_t      raddr_o,
    output beat_t      rdata_o,
    output logic       rvalid_o,
    input  logic [7:0] latency_i,   // idle cycles before the first beat
    input  logic [7:0] gap_i,       // idle cycles between beats
    input  logic [2:0] duty_i       // ready cycles out of every 4
);

    logic       rst_q = 1'b1;
    logic       req_q = 1'b0;
    addr_t      req_addr_q;
    logic [7:0] lat_q;
    logic [7:0] gap_q;
    logic [2:0] duty_q;

    logic  ready_q = 1'b0;
    logic  rvalid_q = 1'b0;
    addr_t raddr_q = '0;
    beat_t rdata_q = '0;

    logic  busy = 1'b0;
    addr_t base;
    int    wait_cnt;
    int    beat;
    int    cyc = 0;

    assign ready_o  = ready_q;
    assign raddr_o  = raddr_q;
    assign rdata_o  = rdata_q;
    assign rvalid_o = rvalid_q;

    function automatic word_t word_at(input addr_t a);
        return a ^ 32'ha13c5a5a;
    endfunction

    // taken at the rising edge, as the DUT sees them
    always @(posedge clk) begin
        rst_q      <= rst;
        req_q      <= read_i && !rst;
        req_addr_q <= addr_i;
        lat_q      <= latency_i;
        gap_q      <= gap_i;
        duty_q     <= duty_i;
    end

    always @(negedge clk) begin
        cyc      = cyc + 1;
        rvalid_q = 1'b0;
        if (rst_q) begin
            busy    = 1'b0;     // burst in flight is dropped
            ready_q = 1'b0;
        end else begin
            if (req_q) begin
                busy     = 1'b1;
                base     = req_addr_q;
                wait_cnt = int'(lat_q);
                beat     = 0;
            end else if (busy) begin
                if (wait_cnt != 0) begin
                    wait_cnt = wait_cnt - 1;
                end else begin
                    rvalid_q = 1'b1;
                    raddr_q  = base;
                    rdata_q  = {word_at(base + addr_t'(8 * beat + 4)),
                                word_at(base + addr_t'(8 * beat))};
                    beat     = beat + 1;
                    wait_cnt = int'(gap_q);
                    if (beat == beats_per_line) busy = 1'b0;
                end
            end
            ready_q = (cyc % 4) < int'(duty_q);
        end
    end

endmodule : bmem_model

`default_nettype wire

//--- verification/tb_fetch.sv
`timescale 1ns/1ps
`default_nettype none

module tb_fetch
import fetch_pkg::*;
();

    localparam int clk_period = 8;
    localparam int n_rows = 6;

    typedef struct packed {
        logic [7:0]  latency;
        logic [7:0]  gap;
        logic [2:0]  duty;          // ready cycles out of 4
        logic [7:0]  deq_pct;       // chance of a pop per cycle
        logic [15:0] n_pkts;
        logic        stall_first;
    } stim_row_t;

    stim_row_t rows [n_rows] = '{
        '{8'd0,  8'd0, 3'd4, 8'd100, 16'd40, 1'b0},
        '{8'd3,  8'd1, 3'd2, 8'd70,  16'd64, 1'b0},
        '{8'd9,  8'd3, 3'd1, 8'd40,  16'd50, 1'b1},
        '{8'd1,  8'd0, 3'd3, 8'd25,  16'd72, 1'b0},
        '{8'd6,  8'd5, 3'd4, 8'd90,  16'd33, 1'b1},
        '{8'd15, 8'd2, 3'd2, 8'd60,  16'd45, 1'b0}
    };

    logic       clk;
    logic       rst;
    logic       dequeue;
    addr_t      bmem_addr;
    logic       bmem_read;
    logic       bmem_ready;
    addr_t      bmem_raddr;
    beat_t      bmem_rdata;
    logic       bmem_rvalid;
    fetch_pkt_t fetch_pkt;
    logic       fetch_empty;
    logic [7:0] mem_latency;
    logic [7:0] mem_gap;
    logic [2:0] mem_duty;

    int          errors = 0;
    int          pulse_cnt = 0;     // read strobes since reset
    int          beats_seen = 0;
    logic        rst_d = 1'b0;
    int unsigned lcg_state = 44138;

    fetch_top uut (
        .clk           (clk),
        .rst           (rst),
        .bmem_addr_o   (bmem_addr),
        .bmem_read_o   (bmem_read),
        .bmem_ready_i  (bmem_ready),
        .bmem_raddr_i  (bmem_raddr),
        .bmem_rdata_i  (bmem_rdata),
        .bmem_rvalid_i (bmem_rvalid),
        .fetch_pkt_o   (fetch_pkt),
        .fetch_empty_o (fetch_empty),
        .dequeue_i     (dequeue)
    );

    bmem_model mem (
        .clk       (clk),
        .rst       (rst),
        .addr_i    (bmem_addr),
        .read_i    (bmem_read),
        .ready_o   (bmem_ready),
        .raddr_o   (bmem_raddr),
        .rdata_o   (bmem_rdata),
        .rvalid_o  (bmem_rvalid),
        .latency_i (mem_latency),
        .gap_i     (mem_gap),
        .duty_i    (mem_duty)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    function automatic word_t expected_inst(input addr_t pc);
        return pc ^ 32'ha13c5a5a;
    endfunction

    function automatic int lines_spanned(input int count);
        addr_t last_pc;
        last_pc = reset_pc + addr_t'(4 * (count - 1));
        return int'(last_pc[31:5] - reset_pc[31:5]) + 1;
    endfunction

    // ready wait, latency, four beats and the trip through adapter, cache and queue
    function automatic int line_cycles(input stim_row_t row);
        return 4 + int'(row.latency) + beats_per_line * (int'(row.gap) + 1) + 8;
    endfunction

    function automatic int unsigned next_random();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return (lcg_state >> 16) & 32'h7fff;
    endfunction

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (actual !== expected) begin
            errors = errors + 1;
            $display("FAIL time=%0t signal=%s expected=%h actual=%h",
                     $time, name, expected, actual);
            $display("Done: errors found");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    task automatic apply_reset(input stim_row_t row);
        @(negedge clk);
        rst         = 1'b1;
        dequeue     = 1'b0;
        mem_latency = row.latency;
        mem_gap     = row.gap;
        mem_duty    = row.duty;
        repeat (2) @(negedge clk);
        rst = 1'b0;
    endtask

    // with no pops the queue fills and the fetch side has to go quiet
    task automatic wait_queue_filled(input stim_row_t row, input int lo_total,
                                     input int hi_total);
        int lo;
        int hi;
        lo = lines_spanned(lo_total);
        hi = lines_spanned(hi_total);
        while (pulse_cnt < lo) @(negedge clk);
        repeat (line_cycles(row) + 2 * queue_depth) @(negedge clk);
        if (pulse_cnt > hi) begin
            check_value("bmem_read_o pulse count", 64'(hi), 64'(pulse_cnt));
        end
    endtask

    task automatic run_row(input stim_row_t row);
        int    k;
        addr_t pc;
        k = 0;
        if (row.stall_first) begin
            while (fetch_empty) @(negedge clk);
            wait_queue_filled(row, queue_depth, queue_depth);
        end
        while (k < int'(row.n_pkts)) begin
            @(negedge clk);
            if (!fetch_empty && (next_random() % 100) < row.deq_pct) begin
                pc = reset_pc + addr_t'(4 * k);
                check_value("fetch_pkt_o.pc", 64'(pc), 64'(fetch_pkt.pc));
                check_value("fetch_pkt_o.inst", 64'(expected_inst(pc)), 64'(fetch_pkt.inst));
                dequeue = 1'b1;
                k = k + 1;
            end else begin
                dequeue = 1'b0;
            end
        end
        @(negedge clk);
        dequeue = 1'b0;
        // a pop into a full queue can leave one slot unused
        wait_queue_filled(row, k + queue_depth - 1, k + queue_depth);
    endtask

    // memory side sampled at the edge the DUT uses
    always @(posedge clk) begin
        if (rst) begin
            if (rst_d) begin
                check_value("bmem_read_o", 64'(0), 64'(bmem_read));
                check_value("fetch_empty_o", 64'(1), 64'(fetch_empty));
            end
            pulse_cnt  = 0;
            beats_seen = 0;
        end else begin
            if (beats_seen < beats_per_line) begin
                check_value("fetch_empty_o", 64'(1), 64'(fetch_empty));
            end
            if (bmem_rvalid) beats_seen = beats_seen + 1;
            if (bmem_read) begin
                check_value("bmem_ready_i", 64'(1), 64'(bmem_ready));
                check_value("bmem_addr_o",
                            64'({reset_pc[31:5], 5'b0} + addr_t'(32 * pulse_cnt)),
                            64'(bmem_addr));
                pulse_cnt = pulse_cnt + 1;
            end
        end
        rst_d = rst;
    end

    initial begin
        rst         = 1'b1;
        dequeue     = 1'b0;
        mem_latency = 8'd0;
        mem_gap     = 8'd0;
        mem_duty    = 3'd4;
        for (int r = 0; r < n_rows; r++) begin
            apply_reset(rows[r]);
            run_row(rows[r]);
        end
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    initial begin
        longint limit;
        limit = 0;
        foreach (rows[i]) begin
            limit += longint'(int'(rows[i].n_pkts) + 3 * queue_depth) * line_cycles(rows[i]);
        end
        #(limit * clk_period);
        $display("watchdog expired after %0d cycles, fetch stream did not complete", limit);
        $display("Done: errors found");
        $fatal(1, "timeout");
    end

endmodule : tb_fetch

`default_nettype wire
